/* rtl/vid_defs.svh */
//==================================================
// video subsystem timing, text geometry and memory sizes
//==================================================
`ifndef VID_DEFS_SVH
`define VID_DEFS_SVH

// horizontal timing in pixel clocks
`define VID_H_VISIBLE    64
`define VID_H_FRONT      8
`define VID_H_SYNC       8
`define VID_H_BACK       16
`define VID_H_OFFSCREEN  (`VID_H_FRONT + `VID_H_SYNC + `VID_H_BACK)
`define VID_H_TOTAL      (`VID_H_OFFSCREEN + `VID_H_VISIBLE)   // 96 clocks per line

// vertical timing in lines, visible lines come first
`define VID_V_VISIBLE    32
`define VID_V_FRONT      2
`define VID_V_SYNC       2
`define VID_V_BACK       4
`define VID_V_TOTAL      (`VID_V_VISIBLE + `VID_V_FRONT + `VID_V_SYNC + `VID_V_BACK)

// active sync levels
`define VID_H_SYNC_POL   1'b0
`define VID_V_SYNC_POL   1'b0

// text geometry
`define VID_CHARS_WIDE   8        // cells per text row
`define VID_FONT_HEIGHT  16       // glyph rows per cell

// memory sizes
`define VID_VRAM_AW      10
`define VID_FONT_AW      12
`define VID_VRAM_DEPTH   (1 << `VID_VRAM_AW)
`define VID_FONT_DEPTH   (1 << `VID_FONT_AW)

`endif

/* rtl/vid_pkg.sv */
//==================================================
// types shared by the video blocks and the testbench
//==================================================
`include "vid_defs.svh"

package vid_pkg;

    typedef logic [15:0] vram_word_t;   // {bg nibble, fg nibble, char code}
    typedef logic [7:0]  font_byte_t;   // glyph row, msb is leftmost pixel

    typedef struct packed {
        logic                    sel;   // port access this cycle
        logic                    we;    // write when set, else read
        logic [`VID_VRAM_AW-1:0] addr;
        vram_word_t              data;
    } vram_req_t;

    typedef struct packed {
        logic                    sel;
        logic                    we;
        logic [`VID_FONT_AW-1:0] addr;  // {char code, glyph row}
        font_byte_t              data;
    } font_req_t;

    typedef struct packed {
        logic [`VID_VRAM_AW-1:0] dest;  // first word address
        logic [`VID_VRAM_AW:0]   count; // words to write
        vram_word_t              start; // value of first word
        vram_word_t              step;  // added per word
    } fill_cmd_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // classic IRGB colors, dark half then bright half
    localparam rgb_t default_palette [16] = '{
        12'h000, 12'h00A, 12'h0A0, 12'h0AA,
        12'hA00, 12'hA0A, 12'hAA0, 12'hAAA,
        12'h555, 12'h55F, 12'h5F5, 12'h5FF,
        12'hF55, 12'hF5F, 12'hFF5, 12'hFFF
    };

endpackage

/* rtl/sync_ram.sv */
//==================================================
// single-port synchronous RAM, one-cycle read latency
//==================================================
`timescale 1ns/1ps

module sync_ram #(
    parameter type data_t = logic [7:0],
    parameter int  DEPTH  = 256
) (
    input  logic                                   clk,
    input  logic [$clog2(DEPTH)+$bits(data_t)+1:0] req_i,   // {sel, we, addr, data}
    output data_t                                  rdata_o
);

    localparam int AW = $clog2(DEPTH);

    typedef struct packed {
        logic          sel;
        logic          we;
        logic [AW-1:0] addr;
        data_t         data;
    } req_t;

    req_t  req;                                            // unpacked view of req_i
    data_t mem [DEPTH];

    assign req = req_t'(req_i);

    always_ff @(posedge clk) begin
        if (req.sel) begin
            if (req.we) begin
                mem[req.addr] <= req.data;                 // write cycle
            end else begin
                rdata_o <= mem[req.addr];                  // read data valid next cycle
            end
        end
    end

endmodule

/* rtl/video_gen.sv */
//==================================================
// text-mode raster generator: sync timing, cell fetch
// sequencer, glyph shifter and palette lookup
//==================================================
`timescale 1ns/1ps
`include "vid_defs.svh"

module video_gen (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                enable_i,
    output logic                blit_cycle_o,  // 1 lets the blitter own the vram port
    output vid_pkg::vram_req_t  vram_req_o,
    input  vid_pkg::vram_word_t vram_data_i,
    output vid_pkg::font_req_t  font_req_o,
    input  vid_pkg::font_byte_t font_data_i,
    output logic [3:0]          red_o,
    output logic [3:0]          green_o,
    output logic [3:0]          blue_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                dv_de_o
);

    localparam int HW = $clog2(`VID_H_TOTAL);
    localparam int VW = $clog2(`VID_V_TOTAL);
    localparam int FW = $clog2(`VID_FONT_HEIGHT);
    localparam logic [HW-1:0] H_MEM_BEGIN = HW'(`VID_H_OFFSCREEN - 9);  // prime the shifter
    localparam logic [HW-1:0] H_MEM_END   = HW'(`VID_H_TOTAL - 9);
    localparam logic [`VID_VRAM_AW-1:0] ROW_STEP = `VID_VRAM_AW'(`VID_CHARS_WIDE);
    localparam logic [1:0] ST_PRE  = 2'd0;                  // front porch
    localparam logic [1:0] ST_SYNC = 2'd1;
    localparam logic [1:0] ST_POST = 2'd2;                  // back porch
    localparam logic [1:0] ST_VIS  = 2'd3;

    logic [1:0]              h_state, h_state_next, v_state, v_state_next;
    logic [HW-1:0]           h_count, h_thr;
    logic [VW-1:0]           v_count, v_thr;
    logic                    h_last, v_last;               // last pixel of line / frame
    logic                    mem_fetch, mem_fetch_next, mem_fetch_sync;
    logic                    fetch_on, fetch_next;         // fetch window while enabled
    logic [2:0]              char_x, char_x_next;
    logic [FW-1:0]           char_y;
    logic [`VID_VRAM_AW-1:0] text_addr, line_addr;
    logic                    vram_sel_q, font_sel_q;
    logic                    tg_enable;                    // enable sampled at frame end
    logic                    dv_ena;
    vid_pkg::font_byte_t     shift_q;                      // glyph row shifting out msb first
    logic [7:0]              color_q, color_tmp;           // {bg, fg} for current / next cell
    logic [3:0]              pix_idx;
    vid_pkg::rgb_t           palette_q [16];

    always_comb begin
        case (h_state)                                     // last count of each h phase
            ST_PRE:  h_thr = HW'(`VID_H_FRONT - 1);
            ST_SYNC: h_thr = HW'(`VID_H_FRONT + `VID_H_SYNC - 1);
            ST_POST: h_thr = HW'(`VID_H_OFFSCREEN - 1);
            default: h_thr = HW'(`VID_H_TOTAL - 1);
        endcase
        case (v_state)                                     // last line of each v phase
            ST_PRE:  v_thr = VW'(`VID_V_VISIBLE + `VID_V_FRONT - 1);
            ST_SYNC: v_thr = VW'(`VID_V_VISIBLE + `VID_V_FRONT + `VID_V_SYNC - 1);
            ST_POST: v_thr = VW'(`VID_V_TOTAL - 1);
            default: v_thr = VW'(`VID_V_VISIBLE - 1);
        endcase
        h_state_next   = (h_count == h_thr) ? h_state + 2'd1 : h_state;
        h_last         = (h_state == ST_VIS) && (h_count == h_thr);
        v_state_next   = (h_last && v_count == v_thr) ? v_state + 2'd1 : v_state;
        v_last         = h_last && (v_state == ST_POST) && (v_count == v_thr);
        mem_fetch_next = (v_state == ST_VIS && h_count == (mem_fetch ? H_MEM_END : H_MEM_BEGIN))
                         ? !mem_fetch : mem_fetch;
        mem_fetch_sync = !mem_fetch && mem_fetch_next;     // window opens, realign cell
        fetch_on       = tg_enable && mem_fetch;
        fetch_next     = tg_enable && mem_fetch_next;
        char_x_next    = mem_fetch_sync ? 3'd0 : char_x + 3'd1;
        dv_ena         = tg_enable && (h_state == ST_VIS) && (v_state == ST_VIS);
        pix_idx        = shift_q[7] ? color_q[3:0] : color_q[7:4];
    end

    // read requests, font address follows the vram word directly
    always_comb begin
        vram_req_o.sel  = vram_sel_q;
        vram_req_o.we   = 1'b0;
        vram_req_o.addr = text_addr;
        vram_req_o.data = '0;
        font_req_o.sel  = font_sel_q;
        font_req_o.we   = 1'b0;
        font_req_o.addr = {vram_data_i[7:0], char_y};
        font_req_o.data = '0;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state      <= ST_PRE;                        // start in front porch of line 0
            v_state      <= ST_VIS;
            h_count      <= '0;
            v_count      <= '0;
            mem_fetch    <= 1'b0;
            char_x       <= '0;
            char_y       <= '0;
            text_addr    <= '0;
            line_addr    <= '0;
            tg_enable    <= 1'b0;
            blit_cycle_o <= 1'b0;
            vram_sel_q   <= 1'b0;
            font_sel_q   <= 1'b0;
            palette_q    <= vid_pkg::default_palette;
            red_o        <= '0;
            green_o      <= '0;
            blue_o       <= '0;
            hsync_o      <= !`VID_H_SYNC_POL;
            vsync_o      <= !`VID_V_SYNC_POL;
            dv_de_o      <= 1'b0;
        end else begin
            h_state   <= h_state_next;
            v_state   <= v_state_next;
            h_count   <= h_last ? '0 : h_count + 1'b1;
            mem_fetch <= mem_fetch_next;
            char_x    <= char_x_next;
            if (h_last) begin
                v_count <= v_last ? '0 : v_count + 1'b1;
            end
            // video owns the port for cell columns 4 and 5
            blit_cycle_o <= !(fetch_next && (char_x_next == 3'd4 || char_x_next == 3'd5));
            vram_sel_q   <= fetch_next && (char_x_next == 3'd4);
            font_sel_q   <= fetch_next && (char_x_next == 3'd5);
            if (fetch_on && char_x == 3'd7) begin
                text_addr <= text_addr + 1'b1;             // next char+attribute
            end
            if (h_last) begin
                if (char_y == FW'(`VID_FONT_HEIGHT - 1)) begin
                    char_y    <= '0;
                    line_addr <= line_addr + ROW_STEP;     // next text row
                    text_addr <= line_addr + ROW_STEP;
                end else begin
                    char_y    <= char_y + 1'b1;
                    text_addr <= line_addr;                // rescan same text row
                end
            end
            if (v_last) begin
                tg_enable <= enable_i;
                char_y    <= '0;
                text_addr <= '0;
                line_addr <= '0;
            end
            red_o   <= '0;                                 // black outside display
            green_o <= '0;
            blue_o  <= '0;
            if (dv_ena) begin
                red_o   <= palette_q[pix_idx].r;
                green_o <= palette_q[pix_idx].g;
                blue_o  <= palette_q[pix_idx].b;
            end
            hsync_o <= (h_state == ST_SYNC) ? `VID_H_SYNC_POL : !`VID_H_SYNC_POL;
            vsync_o <= (v_state == ST_SYNC) ? `VID_V_SYNC_POL : !`VID_V_SYNC_POL;
            dv_de_o <= dv_ena;
        end
    end

    // cell payload, loaded at char_x 5 and 7
    always_ff @(posedge clk) begin
        shift_q <= {shift_q[6:0], 1'b0};
        if (fetch_on && char_x == 3'd5) begin
            color_tmp <= vram_data_i[15:8];                // attribute of next cell
        end
        if (fetch_on && char_x == 3'd7) begin
            shift_q <= font_data_i;
            color_q <= color_tmp;
        end
    end

endmodule

/* rtl/vram_arbiter.sv */
//==================================================
// video RAM port arbiter, slot owned by fetch or blitter
//==================================================
`timescale 1ns/1ps

module vram_arbiter (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               blit_cycle_i,   // slot from video_gen, 1 = blitter
    input  vid_pkg::vram_req_t vid_req_i,
    input  vid_pkg::vram_req_t blt_req_i,
    output logic               blt_gnt_o,
    output vid_pkg::vram_req_t ram_req_o
);

    logic slot_clash;                                      // video request inside a blit slot
    logic slot_err_q;                                      // sticky, read by the bound checks

    always_comb begin
        slot_clash = blit_cycle_i && vid_req_i.sel;
        blt_gnt_o  = blit_cycle_i;
        // the blit slot drops any video request, the blitter keeps its grant
        ram_req_o  = blit_cycle_i ? blt_req_i : vid_req_i;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            slot_err_q <= 1'b0;
        end else if (slot_clash) begin
            slot_err_q <= 1'b1;
        end
    end

endmodule

/* rtl/fill_blitter.sv */
//==================================================
// fill blitter, writes start + i*step over a vram run
//==================================================
`timescale 1ns/1ps
`include "vid_defs.svh"

module fill_blitter (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               start_i,
    input  vid_pkg::fill_cmd_t cmd_i,
    input  logic               gnt_i,          // port granted, one word written
    output vid_pkg::vram_req_t req_o,
    output logic               busy_o,
    output logic               done_o
);

    logic [`VID_VRAM_AW-1:0] addr_q;                       // next word address
    logic [`VID_VRAM_AW:0]   count_q;                      // words still to write
    vid_pkg::vram_word_t     value_q;                      // running fill value
    vid_pkg::vram_word_t     step_q;
    logic                    accept;
    logic                    advance;

    always_comb begin
        accept      = start_i && !busy_o;                  // start ignored while busy
        advance     = busy_o && gnt_i;
        req_o.sel   = busy_o;
        req_o.we    = 1'b1;
        req_o.addr  = addr_q;
        req_o.data  = value_q;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_o <= 1'b0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (accept) begin
                busy_o <= (cmd_i.count != '0);
                done_o <= (cmd_i.count == '0);             // empty run finishes at once
            end else if (advance && count_q == 1) begin
                busy_o <= 1'b0;                            // last word written
                done_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= cmd_i.dest;
            count_q <= cmd_i.count;
            value_q <= cmd_i.start;
            step_q  <= cmd_i.step;
        end else if (advance) begin
            addr_q  <= addr_q + 1'b1;
            count_q <= count_q - 1'b1;
            value_q <= value_q + step_q;
        end
    end

endmodule

/* rtl/video_top.sv */
//==================================================
// text video subsystem top with vram, font RAM and blitter
//==================================================
`timescale 1ns/1ps
`include "vid_defs.svh"

module video_top (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    enable_i,
    input  logic                    font_we_i,       // host font write strobe
    input  logic [`VID_FONT_AW-1:0] font_addr_i,
    input  vid_pkg::font_byte_t     font_data_i,
    input  logic                    fill_start_i,
    input  vid_pkg::fill_cmd_t      fill_cmd_i,
    output logic                    fill_busy_o,
    output logic                    fill_done_o,
    output logic [3:0]              red_o,
    output logic [3:0]              green_o,
    output logic [3:0]              blue_o,
    output logic                    hsync_o,
    output logic                    vsync_o,
    output logic                    dv_de_o
);

    vid_pkg::vram_req_t  vid_req, blt_req, vram_req;
    vid_pkg::font_req_t  vid_font_req, font_req;
    vid_pkg::vram_word_t vram_rdata;
    vid_pkg::font_byte_t font_rdata;
    logic                blit_cycle;
    logic                blt_gnt;

    always_comb begin
        font_req = vid_font_req;
        if (font_we_i) begin                               // host write wins the font port
            font_req.sel  = 1'b1;
            font_req.we   = 1'b1;
            font_req.addr = font_addr_i;
            font_req.data = font_data_i;
        end
    end

    video_gen u_video_gen (
        .clk          (clk),
        .reset_i      (reset_i),
        .enable_i     (enable_i),
        .blit_cycle_o (blit_cycle),
        .vram_req_o   (vid_req),
        .vram_data_i  (vram_rdata),
        .font_req_o   (vid_font_req),
        .font_data_i  (font_rdata),
        .red_o        (red_o),
        .green_o      (green_o),
        .blue_o       (blue_o),
        .hsync_o      (hsync_o),
        .vsync_o      (vsync_o),
        .dv_de_o      (dv_de_o)
    );

    vram_arbiter u_arbiter (
        .clk          (clk),
        .reset_i      (reset_i),
        .blit_cycle_i (blit_cycle),
        .vid_req_i    (vid_req),
        .blt_req_i    (blt_req),
        .blt_gnt_o    (blt_gnt),
        .ram_req_o    (vram_req)
    );

    fill_blitter u_blitter (
        .clk     (clk),
        .reset_i (reset_i),
        .start_i (fill_start_i),
        .cmd_i   (fill_cmd_i),
        .gnt_i   (blt_gnt),
        .req_o   (blt_req),
        .busy_o  (fill_busy_o),
        .done_o  (fill_done_o)
    );

    sync_ram #(
        .data_t (vid_pkg::vram_word_t),
        .DEPTH  (`VID_VRAM_DEPTH)
    ) u_vram (
        .clk     (clk),
        .req_i   (vram_req),
        .rdata_o (vram_rdata)
    );

    sync_ram #(
        .data_t (vid_pkg::font_byte_t),
        .DEPTH  (`VID_FONT_DEPTH)
    ) u_font (
        .clk     (clk),
        .req_i   (font_req),
        .rdata_o (font_rdata)
    );

endmodule

/* tb/video_asserts.sv */
//==================================================
// bound checks on vram slot ownership and blanking
//==================================================
`timescale 1ns/1ps

module video_asserts (
    input logic        clk,
    input logic        reset_i,
    input logic        blit_cycle_i,
    input logic        slot_err_i,                         // arbiter saw a fetch in a blit slot
    input logic        vid_sel_i,                          // vram read from the fetch
    input logic        font_sel_i,                         // font read from the fetch
    input logic [11:0] rgb_i,
    input logic        de_i
);

    // blitter never granted while a fetch read is up
    a_gnt_excl: assert property (@(posedge clk) disable iff (reset_i)
        !slot_err_i)
        else $error("blitter granted while a video fetch is selected");

    a_blank_black: assert property (@(posedge clk) disable iff (reset_i)
        !de_i |-> rgb_i == 12'h000)
        else $error("color outputs active while dv_de is low");

    // video slot is a vram read and then a font read
    a_slot_fetch: assert property (@(posedge clk) disable iff (reset_i)
        $fell(blit_cycle_i) |-> vid_sel_i ##1 (font_sel_i && !blit_cycle_i)
                                ##1 blit_cycle_i [*6])
        else $error("blit slot withheld outside a fetch-window cell");

endmodule

bind video_top video_asserts u_asserts (
    .clk          (clk),
    .reset_i      (reset_i),
    .blit_cycle_i (blit_cycle),
    .slot_err_i   (u_arbiter.slot_err_q),
    .vid_sel_i    (vid_req.sel),
    .font_sel_i   (vid_font_req.sel),
    .rgb_i        ({red_o, green_o, blue_o}),
    .de_i         (dv_de_o)
);

/* tb/video_tb.sv */
//==================================================
// testbench for the text video subsystem, fills vram,
// loads glyphs and scores whole frames against a model
//==================================================
`timescale 1ns/1ps
`include "vid_defs.svh"

module video_tb;

    localparam int LINE_CLKS    = `VID_H_TOTAL;
    localparam int FRAME_CLKS   = `VID_H_TOTAL * `VID_V_TOTAL;
    localparam int FILL_CLKS    = 512;                     // budget for one fill
    localparam int NUM_ROWS     = 4;
    localparam int SCREEN_WORDS = `VID_CHARS_WIDE * (`VID_V_VISIBLE / `VID_FONT_HEIGHT);

    typedef struct packed {
        logic               enable;
        vid_pkg::fill_cmd_t cmd;                           // {dest, count, start, step}
        logic [3:0]         font_skip;                     // lfsr bytes dropped before glyphs
    } row_t;

    localparam row_t ROWS [NUM_ROWS] = '{
        '{1'b1, '{10'd0, 11'd16, 16'h1F41, 16'h0101}, 4'd0},
        '{1'b0, '{10'd4, 11'd8,  16'h7020, 16'h0003}, 4'd2},  // dark row, fill still runs
        '{1'b1, '{10'd0, 11'd40, 16'hE3C0, 16'h1111}, 4'd3},
        '{1'b1, '{10'd9, 11'd5,  16'h4A7F, 16'hF00D}, 4'd1}
    };
    localparam vid_pkg::fill_cmd_t BOGUS_CMD = '{10'd0, 11'd16, 16'hDEAD, 16'h0001};

    string names [NUM_ROWS] = '{"fill_base", "dark_frame", "long_fill", "partial_fill"};

    logic                    clk;
    logic                    reset_i;
    logic                    enable_i;
    logic                    font_we_i;
    logic [`VID_FONT_AW-1:0] font_addr_i;
    vid_pkg::font_byte_t     font_data_i;
    logic                    fill_start_i;
    vid_pkg::fill_cmd_t      fill_cmd_i;
    logic                    fill_busy_o, fill_done_o;
    logic [3:0]              red_o, green_o, blue_o;
    logic                    hsync_o, vsync_o, dv_de_o;

    vid_pkg::vram_word_t vram_model [`VID_VRAM_DEPTH];     // expected vram contents
    vid_pkg::font_byte_t font_model [`VID_FONT_DEPTH];     // glyph table written so far
    logic [7:0]          lfsr_state;
    int                  done_pulses;

    video_top u_dut (
        .clk          (clk),
        .reset_i      (reset_i),
        .enable_i     (enable_i),
        .font_we_i    (font_we_i),
        .font_addr_i  (font_addr_i),
        .font_data_i  (font_data_i),
        .fill_start_i (fill_start_i),
        .fill_cmd_i   (fill_cmd_i),
        .fill_busy_o  (fill_busy_o),
        .fill_done_o  (fill_done_o),
        .red_o        (red_o),
        .green_o      (green_o),
        .blue_o       (blue_o),
        .hsync_o      (hsync_o),
        .vsync_o      (vsync_o),
        .dv_de_o      (dv_de_o)
    );

    always #20 clk = ~clk;

    always @(negedge clk) begin
        if (!reset_i && fill_done_o) begin
            done_pulses <= done_pulses + 1;                // read only at drive points
        end
    end

    // galois lfsr, taps x^8+x^6+x^5+x^4+1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    task automatic lfsr_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            b          = {b[6:0], lfsr_state[0]};          // one step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic stop_failed(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check(input string test, input string what,
                         input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            stop_failed($sformatf("Fail %s %s expected %0h actual %0h", test, what, exp, act));
        end
    endtask

    task automatic at_drive_point;
        @(posedge clk);
        #2;
    endtask

    task automatic wait_vsync_fall;
        logic prev;
        @(negedge clk);
        prev = vsync_o;
        for (int n = 0; n < 2 * FRAME_CLKS; n++) begin
            @(negedge clk);
            if (prev && !vsync_o) begin
                return;
            end
            prev = vsync_o;
        end
        stop_failed("vsync_o stopped pulsing");
    endtask

    task automatic wait_de_high;
        for (int n = 0; n < FRAME_CLKS; n++) begin
            @(negedge clk);
            if (dv_de_o) begin
                return;
            end
        end
        stop_failed("dv_de_o never rose in an enabled frame");
    endtask

    task automatic apply_fill_model(input vid_pkg::fill_cmd_t cmd);
        for (int i = 0; i < int'(cmd.count); i++) begin
            vram_model[`VID_VRAM_AW'(cmd.dest + i)] = 16'(cmd.start + i * cmd.step);
        end
    endtask

    // glyphs for every code on screen, one host write per clock
    task automatic load_glyphs(input int skip);
        logic [7:0] b;
        logic [7:0] code;
        for (int i = 0; i < skip; i++) begin
            lfsr_byte(b);
        end
        for (int a = 0; a < SCREEN_WORDS; a++) begin
            code = vram_model[a][7:0];
            for (int g = 0; g < `VID_FONT_HEIGHT; g++) begin
                lfsr_byte(b);
                font_model[{code, 4'(g)}] = b;
                font_addr_i = {code, 4'(g)};
                font_data_i = b;
                font_we_i   = 1'b1;
                at_drive_point;
            end
        end
        font_we_i = 1'b0;
    endtask

    task automatic run_fill(input string test, input vid_pkg::fill_cmd_t cmd, input int ndone);
        int n;
        fill_cmd_i   = cmd;
        fill_start_i = 1'b1;
        at_drive_point;                                    // accepted at this edge
        fill_cmd_i   = BOGUS_CMD;                          // second start, blitter is busy
        @(negedge clk);
        check(test, "busy after start", 1, fill_busy_o);
        at_drive_point;
        fill_start_i = 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > FILL_CLKS) begin
                stop_failed("fill_done_o never pulsed");
            end
        end while (!fill_done_o);
        check(test, "busy with done", 0, fill_busy_o);
        at_drive_point;
        check(test, "done pulses", ndone, done_pulses);
    endtask

    // one frame from a vsync fall, visible lines of the next frame inside
    task automatic score_frame(input string test, input logic en);
        int                  pix, de_runs, h_falls, h_low, v_low, last_fall, row_y;
        logic                prev_h, prev_de;
        vid_pkg::vram_word_t word;
        vid_pkg::font_byte_t glyph;
        logic [3:0]          idx;
        pix       = 0;
        de_runs   = 0;
        h_falls   = 0;
        h_low     = 0;
        v_low     = 0;
        last_fall = -1;
        prev_h    = hsync_o;
        prev_de   = dv_de_o;
        for (int s = 0; s < FRAME_CLKS; s++) begin
            if (s > 0) begin
                @(negedge clk);
            end
            v_low += !vsync_o;
            h_low += !hsync_o;
            if (!prev_h && hsync_o) begin
                check(test, "hsync width", `VID_H_SYNC, h_low);
                h_low = 0;
            end
            if (prev_h && !hsync_o) begin
                if (last_fall >= 0) begin
                    check(test, "line length", LINE_CLKS, s - last_fall);
                end
                last_fall = s;
                h_falls++;
            end
            if (dv_de_o) begin
                row_y = de_runs;                           // n-th de line is screen row n
                word  = vram_model[(row_y / `VID_FONT_HEIGHT) * `VID_CHARS_WIDE + pix / 8];
                glyph = font_model[{word[7:0], 4'(row_y % `VID_FONT_HEIGHT)}];
                idx   = glyph[7 - pix % 8] ? word[11:8] : word[15:12];
                check(test, "pixel color", vid_pkg::default_palette[idx], {red_o, green_o, blue_o});
                pix++;
            end else begin
                check(test, "color in blanking", 0, {red_o, green_o, blue_o});
                if (prev_de) begin
                    check(test, "de width", `VID_H_VISIBLE, pix);
                    de_runs++;
                    pix = 0;
                end
            end
            prev_h  = hsync_o;
            prev_de = dv_de_o;
        end
        @(negedge clk);
        check(test, "frame length", 0, vsync_o);           // next vsync fall exactly here
        check(test, "vsync width", `VID_V_SYNC * LINE_CLKS, v_low);
        check(test, "lines per frame", `VID_V_TOTAL, h_falls);
        check(test, "de lines", en ? `VID_V_VISIBLE : 0, de_runs);
    endtask

    initial begin
        repeat (NUM_ROWS * (4 * FRAME_CLKS + FILL_CLKS)) @(posedge clk);
        stop_failed("watchdog expired, the test sequence hung");
    end

    initial begin
        clk          = 1'b0;
        reset_i      = 1'b1;
        enable_i     = 1'b0;
        font_we_i    = 1'b0;
        font_addr_i  = '0;
        font_data_i  = '0;
        fill_start_i = 1'b0;
        fill_cmd_i   = '0;
        lfsr_state   = 8'd28;
        done_pulses  = 0;
        repeat (2) @(posedge clk);
        #2;
        reset_i = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            at_drive_point;
            enable_i = 1'b0;
            wait_vsync_fall;                               // dark until enable is sampled
            at_drive_point;
            apply_fill_model(ROWS[r].cmd);
            load_glyphs(ROWS[r].font_skip);
            enable_i = ROWS[r].enable;
            wait_vsync_fall;                               // first frame after enable skipped
            if (ROWS[r].enable) begin
                wait_de_high;                              // fill races the fetch
            end
            at_drive_point;
            run_fill(names[r], ROWS[r].cmd, r + 1);
            wait_vsync_fall;
            score_frame(names[r], ROWS[r].enable);
            at_drive_point;
            check(names[r], "done pulses after frame", r + 1, done_pulses);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+rtl
rtl/vid_pkg.sv
rtl/sync_ram.sv
rtl/video_gen.sv
rtl/vram_arbiter.sv
rtl/fill_blitter.sv
rtl/video_top.sv
tb/video_asserts.sv
tb/video_tb.sv
